// ==== build.f ====
+incdir+design
design/residuPkg.sv
design/memPortIf.sv
design/scratchMemory.sv
design/basicOps.sv
design/longShifter.sv
design/residuSequencer.sv
design/residuFilter.sv
verification/residuFilterTb.sv

// ==== verification/residuFilterTb.sv ====
`timescale 1ns/1ps
`include "residuFilter_settings.svh"

module residuFilterTb;

	localparam int numTests = 10;
	localparam int taps = `RESIDU_ORDER + 1;
	localparam int histLen = `RESIDU_ORDER;
	localparam int sampLen = `RESIDU_ORDER + `RESIDU_LG;
	localparam int runLimit = `RESIDU_LG * 20 + 200;
	localparam int timeoutCycles = numTests * runLimit;
	localparam longint maxWord = 64'sh7FFF_FFFF;
	localparam longint minWord = -64'sh8000_0000;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic hostSel;
	residuPkg::addrT a;
	residuPkg::addrT x;
	residuPkg::addrT y;
	residuPkg::addrT hostWrAddrAy;
	residuPkg::wordT hostWrDataAy;
	logic hostWrEnAy;
	residuPkg::addrT hostWrAddrX;
	residuPkg::sampleT hostWrDataX;
	logic hostWrEnX;
	residuPkg::addrT hostRdAddr;
	logic done;
	residuPkg::wordT rdData;

	// Run length of the last test without an extra start
	int plainCycles = 0;

	//////////////////////////////
	// Test table
	//////////////////////////////

	string testName [numTests];
	residuPkg::sampleT coefTab [numTests][taps];
	logic [15:0] coefHiTab [numTests][taps];
	// Ten history samples, then the inputs
	residuPkg::sampleT sampTab [numTests][sampLen];
	residuPkg::addrT aTab [numTests];
	residuPkg::addrT xTab [numTests];
	residuPkg::addrT yTab [numTests];
	logic busyTab [numTests];
	residuPkg::addrT rawAddrTab [numTests];
	residuPkg::wordT rawWordTab [numTests];
	residuPkg::sampleT expTab [numTests][`RESIDU_LG];

	residuFilter dut
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.hostSel(hostSel),
		.a(a),
		.x(x),
		.y(y),
		.hostWrAddrAy(hostWrAddrAy),
		.hostWrDataAy(hostWrDataAy),
		.hostWrEnAy(hostWrEnAy),
		.hostWrAddrX(hostWrAddrX),
		.hostWrDataX(hostWrDataX),
		.hostWrEnX(hostWrEnX),
		.hostRdAddr(hostRdAddr),
		.done(done),
		.rdData(rdData)
	);

	always #2 clk = ~clk;

	task automatic failRun(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	initial
	begin
		repeat (timeoutCycles) @(posedge clk);
		failRun($sformatf("Timeout: run did not finish within %0d cycles", timeoutCycles));
	end

	task automatic checkSample(input string what, input residuPkg::sampleT expected,
		input residuPkg::sampleT actual);
		if (actual !== expected)
			failRun($sformatf("CHECK FAILED %s expected %0d actual %0d", what, expected, actual));
	endtask

	task automatic checkWord(input string what, input residuPkg::wordT expected,
		input residuPkg::wordT actual);
		if (actual !== expected)
			failRun($sformatf("CHECK FAILED %s expected %h actual %h", what, expected, actual));
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic longint clampWord(input longint v);
		if (v > maxWord)
			return maxWord;
		if (v < minWord)
			return minWord;
		return v;
	endfunction

	// Doubled product where only -32768 squared leaves the range
	function automatic longint multModel(input residuPkg::sampleT p, input residuPkg::sampleT q);
		return clampWord(2 * longint'(p) * longint'(q));
	endfunction

	function automatic residuPkg::sampleT filterModel(input int t, input int n);
		longint acc;
		int j;
		int s;
		acc = multModel(coefTab[t][0], sampTab[t][histLen + n]);
		for (j = 1; j < taps; j++)
			acc = clampWord(acc + multModel(coefTab[t][j], sampTab[t][histLen + n - j]));
		// Stays on the rail once a step overflows
		for (s = 0; s < `RESIDU_SHIFT; s++)
			acc = clampWord(acc * 2);
		acc = clampWord(acc + 32768);
		return residuPkg::sampleT'(acc >>> 16);
	endfunction

	task automatic buildTable();
		int t;
		int k;
		int n;
		for (t = 0; t < numTests; t++)
		begin
			aTab[t] = residuPkg::addrT'(16);
			xTab[t] = residuPkg::addrT'(1024);
			yTab[t] = residuPkg::addrT'(512);
			busyTab[t] = 1'b0;
			rawAddrTab[t] = residuPkg::addrT'($urandom_range(1100, 1300));
			rawWordTab[t] = residuPkg::wordT'($urandom);
			for (k = 0; k < taps; k++)
			begin
				coefTab[t][k] = '0;
				coefHiTab[t][k] = 16'($urandom);
			end
			for (k = 0; k < sampLen; k++)
				sampTab[t][k] = residuPkg::sampleT'($urandom);
		end
		testName[0] = "identity";
		coefTab[0][0] = 16'sd4096;
		testName[1] = "history3";
		coefTab[1][3] = 16'sd4096;
		testName[2] = "history10";
		coefTab[2][`RESIDU_ORDER] = 16'sd4096;
		testName[3] = "saturatePos";
		testName[4] = "saturateNeg";
		testName[5] = "saturateMinSquared";
		for (k = 0; k < taps; k++)
		begin
			coefTab[3][k] = 16'sh7FFF;
			coefTab[4][k] = 16'sh7FFF;
			coefTab[5][k] = 16'sh8000;
		end
		for (k = 0; k < sampLen; k++)
		begin
			sampTab[3][k] = 16'sh7FFF;
			sampTab[4][k] = 16'sh8000;
			sampTab[5][k] = 16'sh8000;
		end
		// Random bases keep a, y and the raw word apart
		for (t = 6; t < numTests; t++)
		begin
			testName[t] = (t == numTests - 1) ? "startWhileBusy" : $sformatf("random%0d", t - 6);
			aTab[t] = residuPkg::addrT'($urandom_range(0, 150));
			yTab[t] = residuPkg::addrT'($urandom_range(300, 900));
			xTab[t] = residuPkg::addrT'($urandom_range(histLen, 2000));
			for (k = 0; k < taps; k++)
				coefTab[t][k] = residuPkg::sampleT'($urandom) >>> (t % 3);
		end
		busyTab[numTests - 1] = 1'b1;
		for (t = 0; t < numTests; t++)
			for (n = 0; n < `RESIDU_LG; n++)
				expTab[t][n] = filterModel(t, n);
	endtask

	//////////////////////////////
	// Host side
	//////////////////////////////

	task automatic loadMemories(input int t);
		int k;
		hostSel = 1'b0;
		a = aTab[t];
		x = xTab[t];
		y = yTab[t];
		for (k = 0; k < taps; k++)
		begin
			hostWrAddrAy = aTab[t] + residuPkg::addrT'(k);
			hostWrDataAy = {coefHiTab[t][k], coefTab[t][k]};
			hostWrEnAy = 1'b1;
			@(negedge clk);
		end
		hostWrAddrAy = rawAddrTab[t];
		hostWrDataAy = rawWordTab[t];
		@(negedge clk);
		hostWrEnAy = 1'b0;
		// History sits just below base x
		for (k = 0; k < sampLen; k++)
		begin
			hostWrAddrX = xTab[t] - residuPkg::addrT'(histLen) + residuPkg::addrT'(k);
			hostWrDataX = sampTab[t][k];
			hostWrEnX = 1'b1;
			@(negedge clk);
		end
		hostWrEnX = 1'b0;
	endtask

	task automatic runFilter(input int t);
		int cycles;
		int doneCount;
		int window;
		cycles = 0;
		doneCount = 0;
		hostSel = 1'b1;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		while (doneCount == 0)
		begin
			@(negedge clk);
			cycles++;
			// Extra start pulse well inside the run
			start = busyTab[t] && (cycles == 20);
			if (done)
				doneCount++;
			if (cycles > runLimit)
				failRun($sformatf("Test %s: done did not arrive within %0d cycles",
					testName[t], runLimit));
		end
		start = 1'b0;
		// An ignored start leaves the run length unchanged
		if (!busyTab[t])
			plainCycles = cycles;
		else if (cycles != plainCycles)
			failRun($sformatf("Test %s: run took %0d cycles instead of %0d",
				testName[t], cycles, plainCycles));
		// Long enough for a whole second run
		window = busyTab[t] ? runLimit : 4;
		repeat (window)
		begin
			@(negedge clk);
			if (done)
				doneCount++;
		end
		if (doneCount != 1)
			failRun($sformatf("Test %s: expected one done pulse but saw %0d",
				testName[t], doneCount));
		hostSel = 1'b0;
	endtask

	task automatic readBack(input int t);
		int k;
		hostRdAddr = rawAddrTab[t];
		@(negedge clk);
		checkWord($sformatf("%s raw word", testName[t]), rawWordTab[t], rdData);
		for (k = 0; k < taps; k++)
		begin
			hostRdAddr = aTab[t] + residuPkg::addrT'(k);
			@(negedge clk);
			checkWord($sformatf("%s a[%0d]", testName[t], k),
				{coefHiTab[t][k], coefTab[t][k]}, rdData);
		end
		for (k = 0; k < `RESIDU_LG; k++)
		begin
			hostRdAddr = yTab[t] + residuPkg::addrT'(k);
			@(negedge clk);
			checkSample($sformatf("%s y[%0d]", testName[t], k), expTab[t][k],
				residuPkg::sampleT'(rdData[15:0]));
			// Upper half is the sign extension
			checkWord($sformatf("%s y[%0d] word", testName[t], k),
				{{16{expTab[t][k][15]}}, expTab[t][k]}, rdData);
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		int t;
		void'($urandom(32'h80f86110));
		rst = 1'b1;
		start = 1'b0;
		hostSel = 1'b0;
		a = '0;
		x = '0;
		y = '0;
		hostWrAddrAy = '0;
		hostWrDataAy = '0;
		hostWrEnAy = 1'b0;
		hostWrAddrX = '0;
		hostWrDataX = '0;
		hostWrEnX = 1'b0;
		hostRdAddr = '0;
		buildTable();
		repeat (5) @(negedge clk);
		rst = 1'b0;
		for (t = 0; t < numTests; t++)
		begin
			loadMemories(t);
			runFilter(t);
			readBack(t);
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== design/residuFilter.sv ====
`timescale 1ns/1ps

module residuFilter
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic hostSel,
	input residuPkg::addrT a,
	input residuPkg::addrT x,
	input residuPkg::addrT y,
	input residuPkg::addrT hostWrAddrAy,
	input residuPkg::wordT hostWrDataAy,
	input logic hostWrEnAy,
	input residuPkg::addrT hostWrAddrX,
	input residuPkg::sampleT hostWrDataX,
	input logic hostWrEnX,
	input residuPkg::addrT hostRdAddr,
	output logic done,
	output residuPkg::wordT rdData
);

	// Sequencer side and memory side of the coefficient/output port
	memPortIf #(.dataT(residuPkg::wordT)) seqAy();
	memPortIf #(.dataT(residuPkg::wordT)) ayPort();
	memPortIf #(.dataT(residuPkg::sampleT)) xPort();

	residuPkg::sampleT multA;
	residuPkg::sampleT multB;
	residuPkg::wordT macAcc;
	residuPkg::wordT roundIn;
	residuPkg::wordT multOut;
	residuPkg::wordT macOut;
	residuPkg::sampleT roundOut;
	logic shReq;
	residuPkg::wordT shOperand;
	logic shDone;
	residuPkg::wordT shResult;

	residuSequencer sequencer
	(
		.clk(clk),
		.rst(rst),
		.start(start),
		.a(a),
		.x(x),
		.y(y),
		.done(done),
		.ayPort(seqAy.master),
		.xPort(xPort.master),
		.multA(multA),
		.multB(multB),
		.macAcc(macAcc),
		.roundIn(roundIn),
		.multOut(multOut),
		.macOut(macOut),
		.roundOut(roundOut),
		.shReq(shReq),
		.shOperand(shOperand),
		.shDone(shDone),
		.shResult(shResult)
	);

	// Coefficients in, outputs back
	scratchMemory #(.dataT(residuPkg::wordT)) memAy (.clk(clk), .port(ayPort.mem));

	// Input samples with history below base x
	scratchMemory #(.dataT(residuPkg::sampleT)) memX (.clk(clk), .port(xPort.mem));

	basicOps ops
	(
		.multA(multA),
		.multB(multB),
		.macAcc(macAcc),
		.roundIn(roundIn),
		.multOut(multOut),
		.macOut(macOut),
		.roundOut(roundOut)
	);

	longShifter shifter
	(
		.clk(clk),
		.rst(rst),
		.req(shReq),
		.operand(shOperand),
		.done(shDone),
		.result(shResult)
	);

	//////////////////////////////
	// Host/sequencer muxes
	//////////////////////////////

	always_comb
	begin
		case (hostSel)
			1'b0:
			begin
				ayPort.wrAddr = hostWrAddrAy;
				ayPort.wrData = hostWrDataAy;
				ayPort.wrEn = hostWrEnAy;
				ayPort.rdAddr = hostRdAddr;
			end
			default:
			begin
				ayPort.wrAddr = seqAy.wrAddr;
				ayPort.wrData = seqAy.wrData;
				ayPort.wrEn = seqAy.wrEn;
				ayPort.rdAddr = seqAy.rdAddr;
			end
		endcase
	end

	assign seqAy.rdData = ayPort.rdData;
	assign rdData = ayPort.rdData;

	// Sample memory writes always come from the host
	assign xPort.wrAddr = hostWrAddrX;
	assign xPort.wrData = hostWrDataX;
	assign xPort.wrEn = hostWrEnX;

endmodule

// ==== design/residuSequencer.sv ====
`timescale 1ns/1ps
`include "residuFilter_settings.svh"

module residuSequencer
(
	input logic clk,
	input logic rst,
	input logic start,
	input residuPkg::addrT a,
	input residuPkg::addrT x,
	input residuPkg::addrT y,
	output logic done,
	memPortIf.master ayPort,
	memPortIf.master xPort,
	output residuPkg::sampleT multA,
	output residuPkg::sampleT multB,
	output residuPkg::wordT macAcc,
	output residuPkg::wordT roundIn,
	input residuPkg::wordT multOut,
	input residuPkg::wordT macOut,
	input residuPkg::sampleT roundOut,
	output logic shReq,
	output residuPkg::wordT shOperand,
	input logic shDone,
	input residuPkg::wordT shResult
);

	localparam residuPkg::addrT firstTap = residuPkg::addrT'(1);
	localparam residuPkg::addrT lastTap = residuPkg::addrT'(`RESIDU_ORDER + 1);
	localparam residuPkg::addrT lastSample = residuPkg::addrT'(`RESIDU_LG - 1);

	residuPkg::seqStateT state;

	// tapIdx is the tap being read, one ahead of the tap in use
	residuPkg::addrT sampleIdx;
	residuPkg::addrT tapIdx;

	residuPkg::wordT acc;
	residuPkg::sampleT outSample;

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= residuPkg::stIdle;
			sampleIdx <= '0;
			tapIdx <= '0;
			shReq <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			shReq <= 1'b0;
			done <= 1'b0;
			case (state)
				residuPkg::stIdle:
				begin
					if (start)
					begin
						sampleIdx <= '0;
						tapIdx <= '0;
						state <= residuPkg::stLoad;
					end
				end
				// Tap 0 read in flight
				residuPkg::stLoad:
				begin
					tapIdx <= tapIdx + 1'b1;
					state <= residuPkg::stAccumulate;
				end
				residuPkg::stAccumulate:
				begin
					tapIdx <= tapIdx + 1'b1;
					if (tapIdx == lastTap)
					begin
						shReq <= 1'b1;
						state <= residuPkg::stShift;
					end
				end
				residuPkg::stShift:
				begin
					if (shDone)
						state <= residuPkg::stWrite;
				end
				residuPkg::stWrite:
				begin
					tapIdx <= '0;
					if (sampleIdx == lastSample)
					begin
						done <= 1'b1;
						state <= residuPkg::stFinish;
					end
					else
					begin
						sampleIdx <= sampleIdx + 1'b1;
						state <= residuPkg::stLoad;
					end
				end
				residuPkg::stFinish:
					state <= residuPkg::stIdle;
				default:
					state <= residuPkg::stIdle;
			endcase
		end
	end

	//////////////////////////////
	// Datapath
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (state == residuPkg::stAccumulate)
			acc <= (tapIdx == firstTap) ? multOut : macOut;
		if (state == residuPkg::stShift && shDone)
			outSample <= roundOut;
	end

	// Coefficient sits in the low half of the word
	assign multA = residuPkg::sampleT'(ayPort.rdData[15:0]);
	assign multB = xPort.rdData;
	assign macAcc = acc;
	assign shOperand = acc;
	assign roundIn = shResult;

	assign ayPort.rdAddr = a + tapIdx;
	assign xPort.rdAddr = x + sampleIdx - tapIdx;

	// Output write, sign-extended
	assign ayPort.wrEn = (state == residuPkg::stWrite);
	assign ayPort.wrAddr = y + sampleIdx;
	assign ayPort.wrData = {{16{outSample[15]}}, outSample};

	// Write half of xPort belongs to the host

	donePulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
	else
		$error("residuSequencer done held longer than one cycle");

endmodule

// ==== design/longShifter.sv ====
`timescale 1ns/1ps
`include "residuFilter_settings.svh"

module longShifter
(
	input logic clk,
	input logic rst,
	input logic req,
	input residuPkg::wordT operand,
	output logic done,
	output residuPkg::wordT result
);

	localparam int countW = $clog2(`RESIDU_SHIFT + 1);

	logic busy;
	logic [countW-1:0] remaining;

	// One L_shl step, sticks at the rail once saturated
	function automatic residuPkg::wordT shiftOne(input residuPkg::wordT v);
		if (v[31] != v[30])
			return v[31] ? 32'sh8000_0000 : 32'sh7FFF_FFFF;
		return {v[30:0], 1'b0};
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			remaining <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (busy)
			begin
				remaining <= remaining - 1'b1;
				if (remaining == countW'(1))
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
			else if (req)
			begin
				busy <= 1'b1;
				remaining <= countW'(`RESIDU_SHIFT);
			end
		end
	end

	// Operand capture, then one bit per busy cycle
	always_ff @(posedge clk)
	begin
		if (busy)
			result <= shiftOne(result);
		else if (req)
			result <= operand;
	end

	// Sequencer must wait for done before the next request
	noReqWhileBusy: assert property (@(posedge clk) disable iff (rst) busy |-> !req)
	else
		$error("longShifter request arrived while busy");

endmodule

// ==== design/basicOps.sv ====
`timescale 1ns/1ps
`include "residuFilter_settings.svh"

module basicOps
(
	input residuPkg::sampleT multA,
	input residuPkg::sampleT multB,
	input residuPkg::wordT macAcc,
	input residuPkg::wordT roundIn,
	output residuPkg::wordT multOut,
	output residuPkg::wordT macOut,
	output residuPkg::sampleT roundOut
);

	localparam residuPkg::wordT maxWord = 32'sh7FFF_FFFF;
	localparam residuPkg::wordT minWord = 32'sh8000_0000;

	// Only -32768 * -32768 lands here
	localparam residuPkg::wordT multLimit = 32'sh4000_0000;

	residuPkg::wordT rawProd;
	residuPkg::wordT rounded;

	//////////////////////////////
	// Shared 32-bit saturating add
	//////////////////////////////

	function automatic residuPkg::wordT satAdd
	(
		input residuPkg::wordT p,
		input residuPkg::wordT q
	);
		logic signed [32:0] wide;
		begin
			wide = {p[31], p} + {q[31], q};
			// Guard bit disagrees with the sign on overflow
			if (wide[32] != wide[31])
				return wide[32] ? minWord : maxWord;
			return wide[31:0];
		end
	endfunction

	//////////////////////////////
	// L_mult
	//////////////////////////////

	assign rawProd = multA * multB;

	always_comb
	begin
		if (rawProd == multLimit)
			multOut = maxWord;
		else
			multOut = rawProd <<< 1;
	end

	//////////////////////////////
	// L_mac
	//////////////////////////////

	// Product saturates first, then the accumulate
	assign macOut = satAdd(macAcc, multOut);

	//////////////////////////////
	// round
	//////////////////////////////

	assign rounded = satAdd(roundIn, `RESIDU_ROUND);
	assign roundOut = rounded[31:16];

endmodule

// ==== design/scratchMemory.sv ====
`timescale 1ns/1ps
`include "residuFilter_settings.svh"

module scratchMemory #(parameter type dataT = residuPkg::wordT)
(
	input logic clk,
	memPortIf.mem port
);

	localparam int depth = 1 << `RESIDU_AW;

	dataT store [0:depth-1];

	// Read returns the old word on a same-address write
	always_ff @(posedge clk)
	begin
		if (port.wrEn)
			store[port.wrAddr] <= port.wrData;
		port.rdData <= store[port.rdAddr];
	end

	// Enable comes from the host or the sequencer through the top-level mux
	wrEnKnown: assert property (@(posedge clk) !$isunknown(port.wrEn))
	else
		$error("scratchMemory write enable is unknown");

endmodule

// ==== design/memPortIf.sv ====
`timescale 1ns/1ps

interface memPortIf #(parameter type dataT = residuPkg::wordT);

	// Write half
	residuPkg::addrT wrAddr;
	dataT wrData;
	logic wrEn;

	// Read half, data one clock after the address
	residuPkg::addrT rdAddr;
	dataT rdData;

	modport mem
	(
		input wrAddr, wrData, wrEn, rdAddr,
		output rdData
	);

	modport master
	(
		output wrAddr, wrData, wrEn, rdAddr,
		input rdData
	);

endinterface

// ==== design/residuPkg.sv ====
`include "residuFilter_settings.svh"

package residuPkg;

	//////////////////////////////
	// Datapath types
	//////////////////////////////

	// Q15 value for coefficients, samples and outputs
	typedef logic signed [15:0] sampleT;

	// Accumulator word, also the coefficient/output memory word
	typedef logic signed [31:0] wordT;

	// Scratch memory address
	typedef logic [`RESIDU_AW-1:0] addrT;

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	typedef enum logic [2:0]
	{
		stIdle,
		stLoad,
		stAccumulate,
		stShift,
		stWrite,
		stFinish
	} seqStateT;

endpackage

// ==== design/residuFilter_settings.svh ====
`ifndef RESIDU_FILTER_SETTINGS_SVH
`define RESIDU_FILTER_SETTINGS_SVH

//////////////////////////////
// Filter shape
//////////////////////////////

// Filter order M, taps run 0..M
`define RESIDU_ORDER 10

// Output samples per run
`define RESIDU_LG 40

//////////////////////////////
// Datapath
//////////////////////////////

// Scratch memory address width
`define RESIDU_AW 11

// Left shift before rounding
`define RESIDU_SHIFT 3

// Added before taking the upper half
`define RESIDU_ROUND 32'sh0000_8000

`endif
